// ==== src/gb_map_pkg.sv ====
package gb_map_pkg;

	localparam int ADR_W = 16;
	localparam int DATA_W = 8;

	localparam logic [ADR_W-1:0] BROM_TOP = 16'h00ff;

	// upper end of each region, checked in address order.
	localparam logic [ADR_W-1:0] ROM_END = 16'h7fff;
	localparam logic [ADR_W-1:0] VRAM_END = 16'h9fff;
	localparam logic [ADR_W-1:0] XRAM_END = 16'hbfff;
	localparam logic [ADR_W-1:0] WRAM_END = 16'hfdff;
	localparam logic [ADR_W-1:0] OAM_END = 16'hfe9f;
	localparam logic [7:0] IO_PAGE = 8'hff;

	localparam logic [7:0] IO_JOYPAD = 8'h00;
	localparam logic [7:0] IO_SERIAL_LO = 8'h01;
	localparam logic [7:0] IO_SERIAL_HI = 8'h02;
	localparam logic [7:0] IO_TIMER_LO = 8'h04;
	localparam logic [7:0] IO_TIMER_HI = 8'h07;
	localparam logic [7:0] IO_INT_FLAG = 8'h0f;
	localparam logic [7:0] IO_SOUND_LO = 8'h10;
	localparam logic [7:0] IO_SOUND_HI = 8'h3f;
	localparam logic [7:0] IO_PPU_LO = 8'h40;
	localparam logic [7:0] IO_PPU_HI = 8'h4b;
	localparam logic [7:0] IO_BROM_REG = 8'h50;
	localparam logic [7:0] IO_HRAM_LO = 8'h80;
	localparam logic [7:0] IO_HRAM_HI = 8'hfe;
	localparam logic [7:0] IO_INT_ENA = 8'hff;

	typedef enum logic [2:0] {none, brom, rom, vram, xram, wram, oam, io} region_e;

	typedef struct packed {
		logic joypad;
		logic serial;
		logic timer;
		logic int_flag;
		logic sound;
		logic ppu;
		logic brom_reg;
		logic hram;
		logic int_ena;
		logic brom;
	} io_sel_t;

	typedef union packed {
		logic [ADR_W-1:0] full;
		struct packed {
			logic [7:0] page;
			logic [7:0] offset;
		} part;
	} cpu_adr_u;

	function automatic region_e decode_region(input logic [ADR_W-1:0] adr, input logic boot_vis);
		cpu_adr_u a;
		region_e r;
		a.full = adr;
		if (a.part.page == IO_PAGE)
			r = io;
		else if (boot_vis && a.full <= BROM_TOP)
			r = brom;
		else if (a.full <= ROM_END)
			r = rom;
		else if (a.full <= VRAM_END)
			r = vram;
		else if (a.full <= XRAM_END)
			r = xram;
		else if (a.full <= WRAM_END)
			r = wram;
		else if (a.full <= OAM_END)
			r = oam;
		else
			r = none;
		return r;
	endfunction

	// brom is left clear here because it follows from the region.
	function automatic io_sel_t decode_io(input logic [7:0] offset);
		io_sel_t sel;
		sel = '0;
		sel.joypad = offset == IO_JOYPAD;
		sel.serial = offset >= IO_SERIAL_LO && offset <= IO_SERIAL_HI;
		sel.timer = offset >= IO_TIMER_LO && offset <= IO_TIMER_HI;
		sel.int_flag = offset == IO_INT_FLAG;
		sel.sound = offset >= IO_SOUND_LO && offset <= IO_SOUND_HI;
		sel.ppu = offset >= IO_PPU_LO && offset <= IO_PPU_HI;
		sel.brom_reg = offset == IO_BROM_REG;
		sel.hram = offset >= IO_HRAM_LO && offset <= IO_HRAM_HI;
		sel.int_ena = offset == IO_INT_ENA;
		return sel;
	endfunction

endpackage

// ==== src/gb_bus_pkg.sv ====
package gb_bus_pkg;

	typedef struct packed {
		logic [gb_map_pkg::ADR_W-1:0] adr;
		logic write;
		logic [gb_map_pkg::DATA_W-1:0] wdata;
	} cpu_cmd_t;

	typedef struct packed {
		logic [gb_map_pkg::ADR_W-1:0] adr;
		logic rd;
		logic wr;
		logic [gb_map_pkg::DATA_W-1:0] wdata;
	} mem_port_t;

	typedef struct packed {
		logic cs_rom;
		logic cs_xram;
		logic cs_wram;
	} ext_sel_t;

	typedef struct packed {
		mem_port_t mem;
		ext_sel_t sel;
	} ext_port_t;

	typedef struct packed {
		gb_map_pkg::io_sel_t sel;
		logic [7:0] adr;
		logic rd;
		logic wr;
		logic [gb_map_pkg::DATA_W-1:0] wdata;
	} io_port_t;

	typedef struct packed {
		logic active;
		logic [gb_map_pkg::ADR_W-1:0] src_adr;
		logic [gb_map_pkg::ADR_W-1:0] oam_adr;
		logic rd;
		logic wr;
		logic [gb_map_pkg::DATA_W-1:0] wdata;
	} dma_bus_t;

	typedef struct packed {
		logic need_vram;
		logic need_oam;
		logic [gb_map_pkg::ADR_W-1:0] adr;
		logic rd;
	} ppu_bus_t;

	// one cpu access as it moves through the pipeline.
	typedef struct packed {
		cpu_cmd_t cmd;
		gb_map_pkg::region_e region;
		gb_map_pkg::io_sel_t io_sel;
	} cpu_access_t;

endpackage

// ==== src/gb_addr_decode.sv ====
`timescale 1ns/1ns

module gb_addr_decode (
	input logic gbclk,
	input logic n_crst_in,
	input logic cpu_req,
	input gb_bus_pkg::cpu_cmd_t cpu_cmd,
	input logic done,
	output gb_bus_pkg::cpu_access_t dec,
	output logic dec_valid
);

	gb_map_pkg::cpu_adr_u cmd_adr;
	gb_map_pkg::region_e region;
	gb_map_pkg::io_sel_t io_sel;
	logic busy;
	logic boot_hide;
	logic accept;

	assign cmd_adr.full = cpu_cmd.adr;
	assign accept = cpu_req && !busy;
	assign region = gb_map_pkg::decode_region(cmd_adr.full, !boot_hide);

	always_comb begin
		io_sel = '0;
		if (region == gb_map_pkg::io)
			io_sel = gb_map_pkg::decode_io(cmd_adr.part.offset);
		// boot rom data sits on the peripheral bus.
		io_sel.brom = region == gb_map_pkg::brom;
	end

	always_ff @(posedge gbclk) begin
		if (!n_crst_in) begin
			busy <= 1'b0;
			dec_valid <= 1'b0;
			boot_hide <= 1'b0;
		end else begin
			dec_valid <= accept;
			if (accept)
				busy <= 1'b1;
			else if (done)
				busy <= 1'b0;
			// once hidden the boot rom stays hidden until reset.
			if (accept && io_sel.brom_reg && cpu_cmd.write && cpu_cmd.wdata != '0)
				boot_hide <= 1'b1;
		end
	end

	always_ff @(posedge gbclk) begin
		if (accept) begin
			dec.cmd <= cpu_cmd;
			dec.region <= region;
			dec.io_sel <= io_sel;
		end
	end

endmodule

// ==== src/gb_bus_arbiter.sv ====
`timescale 1ns/1ns

module gb_bus_arbiter (
	input logic gbclk,
	input logic n_crst_in,
	input gb_bus_pkg::cpu_access_t dec,
	input logic dec_valid,
	input gb_bus_pkg::ppu_bus_t ppu,
	input gb_bus_pkg::dma_bus_t dma,
	input logic [gb_map_pkg::DATA_W-1:0] vram_rdata,
	input logic [gb_map_pkg::DATA_W-1:0] ext_rdata,
	output logic [gb_map_pkg::DATA_W-1:0] dma_rdata,
	output gb_bus_pkg::mem_port_t vram,
	output gb_bus_pkg::mem_port_t oam,
	output gb_bus_pkg::ext_port_t ext,
	output gb_bus_pkg::io_port_t io,
	output gb_bus_pkg::cpu_access_t issued,
	output logic issue
);

	gb_bus_pkg::cpu_access_t held;
	gb_map_pkg::region_e dma_region;
	logic pend;
	logic dma_vram;
	logic dma_ext;
	logic blocked;

	function automatic logic is_ext(input gb_map_pkg::region_e r);
		return r == gb_map_pkg::rom || r == gb_map_pkg::xram || r == gb_map_pkg::wram;
	endfunction

	function automatic gb_bus_pkg::ext_sel_t ext_sel_of(input gb_map_pkg::region_e r);
		gb_bus_pkg::ext_sel_t sel;
		sel.cs_rom = r == gb_map_pkg::rom;
		sel.cs_xram = r == gb_map_pkg::xram;
		sel.cs_wram = r == gb_map_pkg::wram;
		return sel;
	endfunction

	// dma never sees the boot rom.
	assign dma_region = gb_map_pkg::decode_region(dma.src_adr, 1'b0);
	assign dma_vram = dma.active && dma_region == gb_map_pkg::vram;
	assign dma_ext = dma.active && is_ext(dma_region);

	assign dma_rdata = dma_region == gb_map_pkg::vram ? vram_rdata :
		is_ext(dma_region) ? ext_rdata : 8'hff;

	always_comb begin
		case (held.region)
		gb_map_pkg::vram: blocked = ppu.need_vram || dma_vram;
		gb_map_pkg::oam: blocked = ppu.need_oam || dma.active;
		gb_map_pkg::rom, gb_map_pkg::xram, gb_map_pkg::wram: blocked = dma_ext;
		default: blocked = 1'b0;
		endcase
	end

	// checked in the same cycle as the strobe, so a late claim still wins.
	assign issue = pend && !blocked;
	assign issued = held;

	always_ff @(posedge gbclk) begin
		if (!n_crst_in)
			pend <= 1'b0;
		else if (dec_valid)
			pend <= 1'b1;
		else if (issue)
			pend <= 1'b0;
	end

	always_ff @(posedge gbclk) begin
		if (dec_valid)
			held <= dec;
	end

	always_comb begin
		vram = '{adr: held.cmd.adr, rd: 1'b0, wr: 1'b0, wdata: held.cmd.wdata};
		if (ppu.need_vram) begin
			vram.adr = ppu.adr;
			vram.rd = ppu.rd;
		end else if (dma_vram) begin
			vram.adr = dma.src_adr;
			vram.rd = dma.rd;
		end else if (issue && held.region == gb_map_pkg::vram) begin
			vram.rd = !held.cmd.write;
			vram.wr = held.cmd.write;
		end
	end

	always_comb begin
		oam = '{adr: held.cmd.adr, rd: 1'b0, wr: 1'b0, wdata: held.cmd.wdata};
		if (ppu.need_oam) begin
			oam.adr = ppu.adr;
			oam.rd = ppu.rd;
		end else if (dma.active) begin
			oam.adr = dma.oam_adr;
			oam.wr = dma.wr;
			oam.wdata = dma.wdata;
		end else if (issue && held.region == gb_map_pkg::oam) begin
			oam.rd = !held.cmd.write;
			oam.wr = held.cmd.write;
		end
	end

	always_comb begin
		ext.mem = '{adr: held.cmd.adr, rd: 1'b0, wr: 1'b0, wdata: held.cmd.wdata};
		ext.sel = '0;
		if (dma_ext) begin
			ext.mem.adr = dma.src_adr;
			ext.mem.rd = dma.rd;
			ext.sel = ext_sel_of(dma_region);
		end else if (issue && is_ext(held.region)) begin
			ext.mem.rd = !held.cmd.write;
			ext.mem.wr = held.cmd.write;
			ext.sel = ext_sel_of(held.region);
		end
	end

	always_comb begin
		io.sel = '0;
		io.adr = held.cmd.adr[7:0];
		io.rd = 1'b0;
		io.wr = 1'b0;
		io.wdata = held.cmd.wdata;
		if (issue && (held.region == gb_map_pkg::io || held.region == gb_map_pkg::brom)) begin
			io.sel = held.io_sel;
			io.rd = !held.cmd.write;
			io.wr = held.cmd.write;
		end
	end

endmodule

// ==== src/gb_read_return.sv ====
`timescale 1ns/1ns

module gb_read_return (
	input logic gbclk,
	input logic n_crst_in,
	input gb_bus_pkg::cpu_access_t issued,
	input logic issue,
	input logic [gb_map_pkg::DATA_W-1:0] vram_rdata,
	input logic [gb_map_pkg::DATA_W-1:0] oam_rdata,
	input logic [gb_map_pkg::DATA_W-1:0] ext_rdata,
	input logic [gb_map_pkg::DATA_W-1:0] io_rdata,
	input logic cpu_req,
	output logic cpu_ack,
	output logic [gb_map_pkg::DATA_W-1:0] cpu_rdata,
	output logic done
);

	logic issue_d;
	logic [gb_map_pkg::DATA_W-1:0] src_data;

	// sources answer one cycle after the strobe, while issued is still held.
	always_comb begin
		case (issued.region)
		gb_map_pkg::vram: src_data = vram_rdata;
		gb_map_pkg::oam: src_data = oam_rdata;
		gb_map_pkg::rom, gb_map_pkg::xram, gb_map_pkg::wram: src_data = ext_rdata;
		gb_map_pkg::io, gb_map_pkg::brom: src_data = |issued.io_sel ? io_rdata : 8'hff;
		default: src_data = 8'hff;
		endcase
	end

	always_ff @(posedge gbclk) begin
		if (!n_crst_in) begin
			issue_d <= 1'b0;
			cpu_ack <= 1'b0;
			done <= 1'b0;
		end else begin
			issue_d <= issue;
			done <= 1'b0;
			if (issue_d) begin
				cpu_ack <= 1'b1;
			end else if (cpu_ack && !cpu_req) begin
				cpu_ack <= 1'b0;
				done <= 1'b1;
			end
		end
	end

	always_ff @(posedge gbclk) begin
		if (issue_d)
			cpu_rdata <= src_data;
	end

endmodule

// ==== src/gb_bus_top.sv ====
`timescale 1ns/1ns

module gb_bus_top (
	input logic gbclk,
	input logic n_crst_in,
	input logic cpu_req,
	input gb_bus_pkg::cpu_cmd_t cpu_cmd,
	output logic cpu_ack,
	output logic [gb_map_pkg::DATA_W-1:0] cpu_rdata,
	input gb_bus_pkg::ppu_bus_t ppu,
	input gb_bus_pkg::dma_bus_t dma,
	output logic [gb_map_pkg::DATA_W-1:0] dma_rdata,
	output gb_bus_pkg::mem_port_t vram,
	input logic [gb_map_pkg::DATA_W-1:0] vram_rdata,
	output gb_bus_pkg::mem_port_t oam,
	input logic [gb_map_pkg::DATA_W-1:0] oam_rdata,
	output gb_bus_pkg::ext_port_t ext,
	input logic [gb_map_pkg::DATA_W-1:0] ext_rdata,
	output gb_bus_pkg::io_port_t io,
	input logic [gb_map_pkg::DATA_W-1:0] io_rdata
);

	gb_bus_pkg::cpu_access_t dec;
	gb_bus_pkg::cpu_access_t issued;
	logic dec_valid;
	logic issue;
	logic done;

	gb_addr_decode u_decode (
		.gbclk(gbclk),
		.n_crst_in(n_crst_in),
		.cpu_req(cpu_req),
		.cpu_cmd(cpu_cmd),
		.done(done),
		.dec(dec),
		.dec_valid(dec_valid)
	);

	gb_bus_arbiter u_arbiter (
		.gbclk(gbclk),
		.n_crst_in(n_crst_in),
		.dec(dec),
		.dec_valid(dec_valid),
		.ppu(ppu),
		.dma(dma),
		.vram_rdata(vram_rdata),
		.ext_rdata(ext_rdata),
		.dma_rdata(dma_rdata),
		.vram(vram),
		.oam(oam),
		.ext(ext),
		.io(io),
		.issued(issued),
		.issue(issue)
	);

	gb_read_return u_return (
		.gbclk(gbclk),
		.n_crst_in(n_crst_in),
		.issued(issued),
		.issue(issue),
		.vram_rdata(vram_rdata),
		.oam_rdata(oam_rdata),
		.ext_rdata(ext_rdata),
		.io_rdata(io_rdata),
		.cpu_req(cpu_req),
		.cpu_ack(cpu_ack),
		.cpu_rdata(cpu_rdata),
		.done(done)
	);

endmodule

// ==== include/gb_bus_checks.svh ====
`ifndef GB_BUS_CHECKS_SVH
`define GB_BUS_CHECKS_SVH

task automatic report_fail(
	input string name,
	input string field,
	input logic [31:0] exp,
	input logic [31:0] act
);
	$display("CHECK FAILED %s %s: expected %0h, actual %0h", name, field, exp, act);
	$display("test failed");
	$fatal(1, "mismatch in %s", name);
endtask

task automatic check_byte(
	input string name,
	input logic [gb_map_pkg::DATA_W-1:0] exp,
	input logic [gb_map_pkg::DATA_W-1:0] act
);
	if (act !== exp)
		report_fail(name, "rdata", 32'(exp), 32'(act));
endtask

task automatic check_ext_sel(
	input string name,
	input gb_bus_pkg::ext_sel_t exp,
	input gb_bus_pkg::ext_sel_t act
);
	if (act !== exp)
		report_fail(name, "ext_sel", 32'(exp), 32'(act));
endtask

// io_sel carries the boot rom bit too.
task automatic check_io_sel(
	input string name,
	input gb_map_pkg::io_sel_t exp,
	input gb_map_pkg::io_sel_t act
);
	if (act !== exp)
		report_fail(name, "io_sel", 32'(exp), 32'(act));
endtask

task automatic check_mem_port(
	input string name,
	input gb_bus_pkg::mem_port_t exp,
	input gb_bus_pkg::mem_port_t act
);
	if (act !== exp)
		report_fail(name, "port", 32'(exp), 32'(act));
endtask

`endif

// ==== verif/gb_bus_tb.sv ====
`timescale 1ns/1ns

module gb_bus_tb;

	typedef struct packed {
		logic write;
		logic [gb_map_pkg::ADR_W-1:0] adr;
		logic [gb_map_pkg::DATA_W-1:0] wdata;
		logic [7:0] len;
		logic [gb_map_pkg::DATA_W-1:0] rdata;
		gb_bus_pkg::ext_sel_t ext_sel;
		gb_map_pkg::io_sel_t io_sel;
	} test_vec_t;

	logic gbclk = 1'b0;
	logic n_crst_in;
	logic cpu_req;
	gb_bus_pkg::cpu_cmd_t cpu_cmd;
	logic cpu_ack;
	logic [gb_map_pkg::DATA_W-1:0] cpu_rdata;
	gb_bus_pkg::ppu_bus_t ppu;
	gb_bus_pkg::dma_bus_t dma;
	logic [gb_map_pkg::DATA_W-1:0] dma_rdata;
	gb_bus_pkg::mem_port_t vram;
	gb_bus_pkg::mem_port_t oam;
	gb_bus_pkg::ext_port_t ext;
	gb_bus_pkg::io_port_t io;
	logic [gb_map_pkg::DATA_W-1:0] vram_rdata = 8'h00;
	logic [gb_map_pkg::DATA_W-1:0] oam_rdata = 8'h00;
	logic [gb_map_pkg::DATA_W-1:0] ext_rdata = 8'h00;
	logic [gb_map_pkg::DATA_W-1:0] io_rdata = 8'h00;

	test_vec_t vecs[$];
	string names[$];
	string kinds[$];
	int cycle_cnt = 0;
	int cycle_limit;
	logic ack_seen = 1'b0;
	logic req_last = 1'b0;

	`include "gb_bus_checks.svh"

	gb_bus_top u_dut (
		.gbclk(gbclk),
		.n_crst_in(n_crst_in),
		.cpu_req(cpu_req),
		.cpu_cmd(cpu_cmd),
		.cpu_ack(cpu_ack),
		.cpu_rdata(cpu_rdata),
		.ppu(ppu),
		.dma(dma),
		.dma_rdata(dma_rdata),
		.vram(vram),
		.vram_rdata(vram_rdata),
		.oam(oam),
		.oam_rdata(oam_rdata),
		.ext(ext),
		.ext_rdata(ext_rdata),
		.io(io),
		.io_rdata(io_rdata)
	);

	always #20 gbclk = ~gbclk;

	// each source answers with its own byte in the cycle after rd.
	always @(posedge gbclk) begin
		vram_rdata <= vram.rd ? 8'h11 : 8'h00;
		oam_rdata <= oam.rd ? 8'h22 : 8'h00;
		ext_rdata <= ext.mem.rd ? 8'h33 : 8'h00;
		io_rdata <= io.rd ? 8'h44 : 8'h00;
	end

	always @(posedge gbclk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit)
			abort_run("the run went past its cycle limit without finishing");
	end

	// four-phase order on the cpu side.
	// req_last is the req level the DUT saw at the edge just before this sample.
	always @(negedge gbclk) begin
		if (!n_crst_in) begin
			ack_seen = 1'b0;
			req_last = 1'b0;
		end else if (cpu_ack && !ack_seen && !req_last)
			abort_run("cpu_ack rose while cpu_req was low");
		else if (!cpu_ack && ack_seen && req_last)
			abort_run("cpu_ack fell while cpu_req was still high");
		else begin
			ack_seen = cpu_ack;
			req_last = cpu_req;
		end
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1, "run stopped");
	endtask

	task automatic load_tests();
		int fd;
		int n;
		int len;
		string line;
		string nm;
		string rw;
		string kind;
		logic [15:0] adr;
		logic [7:0] wdata;
		logic [7:0] rdata;
		logic [2:0] ext_bits;
		logic [9:0] io_bits;
		fd = $fopen("verif/gb_bus_tests.txt", "r");
		if (fd == 0)
			abort_run("cannot open verif/gb_bus_tests.txt");
		else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 1 && line[0] != "#") begin
					n = $sscanf(line, "%s %s %h %h %s %d %h %h %h", nm, rw, adr, wdata,
						kind, len, rdata, ext_bits, io_bits);
					if (n != 9)
						abort_run({"malformed line in the test file: ", line});
					else begin
						names.push_back(nm);
						kinds.push_back(kind);
						vecs.push_back('{write: rw == "w", adr: adr, wdata: wdata,
							len: 8'(len), rdata: rdata, ext_sel: ext_bits, io_sel: io_bits});
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic drive_block(input string kind, input logic on);
		gb_bus_pkg::ppu_bus_t p;
		gb_bus_pkg::dma_bus_t d;
		p = '0;
		d = '0;
		if (on && kind == "ppu_vram")
			p = '{need_vram: 1'b1, need_oam: 1'b0, adr: 16'h8000, rd: 1'b1};
		else if (on && kind == "ppu_oam")
			p = '{need_vram: 1'b0, need_oam: 1'b1, adr: 16'hfe00, rd: 1'b1};
		else if (on && kind == "dma_vram")
			d = '{active: 1'b1, src_adr: 16'h8000, oam_adr: 16'hfe00, rd: 1'b1, wr: 1'b1,
				wdata: 8'h5c};
		else if (on && kind == "dma_ext")
			d = '{active: 1'b1, src_adr: 16'hc000, oam_adr: 16'hfe00, rd: 1'b1, wr: 1'b1,
				wdata: 8'h5c};
		ppu <= p;
		dma <= d;
	endtask

	task automatic check_reset_state();
		check_byte("reset_ack", 8'h00, {7'b0, cpu_ack});
		check_byte("reset_strobes", 8'h00, {vram.rd, vram.wr, oam.rd, oam.wr,
			ext.mem.rd, ext.mem.wr, io.rd, io.wr});
		check_ext_sel("reset_ext_sel", '0, ext.sel);
		check_io_sel("reset_io_sel", '0, io.sel);
	endtask

	task automatic run_test(input int i);
		test_vec_t v;
		string kind;
		int cnt;
		logic block_on;
		gb_bus_pkg::ext_sel_t got_ext;
		gb_map_pkg::io_sel_t got_io;
		gb_bus_pkg::mem_port_t exp_port;
		v = vecs[i];
		kind = kinds[i];
		cnt = 0;
		block_on = kind != "none";
		got_ext = '0;
		got_io = '0;
		// the cpu access carries its own address and data onto whichever port it strobes.
		exp_port = '{adr: v.adr, rd: !v.write, wr: v.write, wdata: v.wdata};
		repeat ($urandom % 4) @(posedge gbclk);
		@(posedge gbclk);
		drive_block(kind, block_on);
		cpu_req <= 1'b1;
		cpu_cmd <= '{adr: v.adr, write: v.write, wdata: v.wdata};
		@(negedge gbclk);
		while (!cpu_ack || block_on) begin
			if (block_on) begin
				check_byte({names[i], "_ack"}, 8'h00, {7'b0, cpu_ack});
				// vram data shows up one cycle after the dma read starts.
				if (kind == "dma_vram" && cnt > 0)
					check_byte({names[i], "_dma_rdata"}, 8'h11, dma_rdata);
			end else begin
				if (vram.rd || vram.wr)
					check_mem_port({names[i], "_vram"}, exp_port, vram);
				if (oam.rd || oam.wr)
					check_mem_port({names[i], "_oam"}, exp_port, oam);
				if (ext.mem.rd || ext.mem.wr) begin
					got_ext = ext.sel;
					check_mem_port({names[i], "_ext"}, exp_port, ext.mem);
				end
				if (io.rd || io.wr)
					got_io = io.sel;
			end
			cnt++;
			@(posedge gbclk);
			if (block_on && cnt >= int'(v.len)) begin
				drive_block(kind, 1'b0);
				block_on = 1'b0;
			end
			@(negedge gbclk);
		end
		if (!v.write)
			check_byte(names[i], v.rdata, cpu_rdata);
		check_ext_sel(names[i], v.ext_sel, got_ext);
		check_io_sel(names[i], v.io_sel, got_io);
		@(posedge gbclk);
		cpu_req <= 1'b0;
		@(negedge gbclk);
		while (cpu_ack)
			@(negedge gbclk);
	endtask

	initial begin
		void'($urandom(32'h815e));
		n_crst_in = 1'b0;
		cpu_req = 1'b0;
		cpu_cmd = '0;
		ppu = '0;
		dma = '0;
		load_tests();
		if (vecs.size() == 0)
			abort_run("no tests found in verif/gb_bus_tests.txt");
		else begin
			cycle_limit = 16;
			foreach (vecs[i])
				cycle_limit += int'(vecs[i].len) + 16;
			repeat (16) @(posedge gbclk);
			n_crst_in <= 1'b1;
			@(negedge gbclk);
			check_reset_state();
			foreach (vecs[i])
				run_test(i);
			@(posedge gbclk);
			$display("test passed");
			$finish;
		end
	end

endmodule

// ==== verif/gb_bus_tests.txt ====
# name rw(r/w) adr wdata block len rdata ext_sel(rom,xram,wram) io_sel(joypad..brom)
# values in hex except len, which is in cycles; rdata is ignored for writes
brom_read r 0010 00 none 0 44 0 001
vram_read r 8000 00 none 0 11 0 000
xram_read r a000 00 none 0 33 2 000
wram_read r c000 00 none 0 33 1 000
echo_read r e000 00 none 0 33 1 000
oam_read r fe00 00 none 0 22 0 000
rom_read r 4000 00 none 0 33 4 000
unmapped_read r fea0 00 none 0 ff 0 000
io_hole_read r ff03 00 none 0 ff 0 000
joypad_read r ff00 00 none 0 44 0 200
serial_read r ff01 00 none 0 44 0 100
timer_write w ff05 5a none 0 00 0 080
int_flag_read r ff0f 00 none 0 44 0 040
sound_read r ff20 00 none 0 44 0 020
ppu_reg_write w ff40 91 none 0 00 0 010
hram_read r ff80 00 none 0 44 0 004
int_ena_read r ffff 00 none 0 44 0 002
wram_write w d000 a5 none 0 00 1 000
vram_ppu r 9000 00 ppu_vram 6 11 0 000
oam_ppu r fe10 00 ppu_oam 5 22 0 000
vram_dma r 8100 00 dma_vram 7 11 0 000
oam_dma w fe20 77 dma_vram 4 00 0 000
wram_dma r c100 00 dma_ext 8 33 1 000
brom_zero_write w ff50 00 none 0 00 0 008
brom_still_read r 0010 00 none 0 44 0 001
brom_hide w ff50 01 none 0 00 0 008
rom_low_read r 0010 00 none 0 33 4 000

// ==== list.f ====
+incdir+include
src/gb_map_pkg.sv
src/gb_bus_pkg.sv
src/gb_addr_decode.sv
src/gb_bus_arbiter.sv
src/gb_read_return.sv
src/gb_bus_top.sv
verif/gb_bus_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --top-module gb_bus_tb -f list.f -o gb_bus_sim

out=$(./obj_dir/gb_bus_sim || true)
echo "$out"

if echo "$out" | grep -qx "test passed"; then
	exit 0
fi
exit 1
